//--- rtl/video_mode_params.svh
`ifndef VIDEO_MODE_PARAMS_SVH
`define VIDEO_MODE_PARAMS_SVH

////////////////////
// Switch codes
////////////////////
`define VM_SW_VGA         4'b0000
`define VM_SW_SVGA        4'b0001
`define VM_SW_XGA         4'b0011
`define VM_SW_HDTV720P    4'b0010
`define VM_SW_SXGA        4'b1000
`define VM_SW_CAMERA      4'b1001

`define VM_COORD_W        11
`define VM_MD_W           8
`define VM_DEBOUNCE_CYCLES 16   // Short for simulation

// Synthesizer command codes, sent MSB first
`define VM_CMD_D          2'b10
`define VM_CMD_M          2'b11

////////////////////
// Format timings
////////////////////
// 640x480@60, 25 MHz
`define VM_VGA_HPIXELS    11'd640
`define VM_VGA_HFP        11'd16
`define VM_VGA_HSPW       11'd96
`define VM_VGA_HBP        11'd48
`define VM_VGA_VLINES     11'd480
`define VM_VGA_VFP        11'd11
`define VM_VGA_VSPW       11'd2
`define VM_VGA_VBP        11'd31
`define VM_VGA_NEGSYNC    1'b1
`define VM_VGA_PCLK_M     8'd1
`define VM_VGA_PCLK_D     8'd3

// 800x600@60, 40 MHz
`define VM_SVGA_HPIXELS   11'd800
`define VM_SVGA_HFP       11'd40
`define VM_SVGA_HSPW      11'd128
`define VM_SVGA_HBP       11'd88
`define VM_SVGA_VLINES    11'd600
`define VM_SVGA_VFP       11'd1
`define VM_SVGA_VSPW      11'd4
`define VM_SVGA_VBP       11'd23
`define VM_SVGA_NEGSYNC   1'b0
`define VM_SVGA_PCLK_M    8'd3
`define VM_SVGA_PCLK_D    8'd4

// 1024x768@60, 65 MHz
`define VM_XGA_HPIXELS    11'd1024
`define VM_XGA_HFP        11'd24
`define VM_XGA_HSPW       11'd136
`define VM_XGA_HBP        11'd160
`define VM_XGA_VLINES     11'd768
`define VM_XGA_VFP        11'd3
`define VM_XGA_VSPW       11'd6
`define VM_XGA_VBP        11'd29
`define VM_XGA_NEGSYNC    1'b1
`define VM_XGA_PCLK_M     8'd12
`define VM_XGA_PCLK_D     8'd9

// 1280x1024@60, 108 MHz
`define VM_SXGA_HPIXELS   11'd1280
`define VM_SXGA_HFP       11'd48
`define VM_SXGA_HSPW      11'd112
`define VM_SXGA_HBP       11'd248
`define VM_SXGA_VLINES    11'd1024
`define VM_SXGA_VFP       11'd1
`define VM_SXGA_VSPW      11'd3
`define VM_SXGA_VBP       11'd38
`define VM_SXGA_NEGSYNC   1'b0
`define VM_SXGA_PCLK_M    8'd53
`define VM_SXGA_PCLK_D    8'd24

// Camera 720p variant
`define VM_CAMERA_HPIXELS 11'd1280
`define VM_CAMERA_HFP     11'd110
`define VM_CAMERA_HSPW    11'd39
`define VM_CAMERA_HBP     11'd220
`define VM_CAMERA_VLINES  11'd720
`define VM_CAMERA_VFP     11'd4
`define VM_CAMERA_VSPW    11'd4
`define VM_CAMERA_VBP     11'd22
`define VM_CAMERA_NEGSYNC 1'b0
`define VM_CAMERA_PCLK_M  8'd134
`define VM_CAMERA_PCLK_D  8'd90

// 1280x720@60, 74.25 MHz, also the default
`define VM_HDTV720P_HPIXELS 11'd1280
`define VM_HDTV720P_HFP     11'd110
`define VM_HDTV720P_HSPW    11'd40
`define VM_HDTV720P_HBP     11'd220
`define VM_HDTV720P_VLINES  11'd720
`define VM_HDTV720P_VFP     11'd5
`define VM_HDTV720P_VSPW    11'd5
`define VM_HDTV720P_VBP     11'd20
`define VM_HDTV720P_NEGSYNC 1'b0
`define VM_HDTV720P_PCLK_M  8'd247
`define VM_HDTV720P_PCLK_D  8'd166

`endif

//--- rtl/video_mode_pkg.sv
`include "video_mode_params.svh"

package video_mode_pkg;

	typedef logic [`VM_COORD_W-1:0] coord_t;   // Raster position or compare point
	typedef logic [3:0]             mode_sel_t; // Switch code
	typedef logic [`VM_MD_W-1:0]    md_val_t;   // Synthesizer M or D, minus one

	// Compare points of one format
	typedef struct packed {
		coord_t hsblnk;   // Last live pixel
		coord_t hssync;   // Sync starts after this
		coord_t hesync;   // Last sync pixel
		coord_t heblnk;   // Last pixel of line
		coord_t vsblnk;
		coord_t vssync;
		coord_t vesync;
		coord_t veblnk;
		logic   neg_sync; // Active low syncs
	} vid_timing_t;

	typedef struct packed {
		md_val_t m;
		md_val_t d;
	} md_pair_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} vid_sync_t;

	// Synthesizer programming sequence
	typedef enum logic [2:0] {
		IDLE,
		SHIFT_D,
		GAP_D,
		SHIFT_M,
		GAP_M,
		GO,
		WAIT_DONE
	} prog_state_t;

endpackage

//--- rtl/switch_debounce.sv
`timescale 1ns/10ps
`include "video_mode_params.svh"

module switch_debounce (
	input  logic                     clk50m_bufg,
	input  logic                     RSTBTN,
	input  video_mode_pkg::mode_sel_t sw,
	output video_mode_pkg::mode_sel_t mode_sel,
	output logic                     mode_change
);
	import video_mode_pkg::*;

	localparam int DEB_W = $clog2(`VM_DEBOUNCE_CYCLES);
	localparam logic [DEB_W-1:0] DEB_MAX = DEB_W'(`VM_DEBOUNCE_CYCLES - 1);

	mode_sel_t        sw_meta;      // First synchronizer stage
	mode_sel_t        sw_sync;
	mode_sel_t        sw_last;      // Previous synchronized sample
	logic [DEB_W-1:0] stable_cnt;   // Cycles the code has held
	logic             accepted_vld; // Nothing accepted after reset
	logic             held;

	////////////////////
	// Synchronizer
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
		sw_last <= sw_sync;
	end

	// Stable long enough
	assign held = (stable_cnt == DEB_MAX) && (sw_sync == sw_last);

	////////////////////
	// Stability timer
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			stable_cnt   <= '0;
			accepted_vld <= 1'b0;
			mode_change  <= 1'b0;
		end else begin
			mode_change <= 1'b0;
			if (sw_sync != sw_last)
				stable_cnt <= DEB_W'(1); // Current cycle is the first of the new code
			else if (stable_cnt != DEB_MAX)
				stable_cnt <= stable_cnt + 1'b1; // Saturates at DEB_MAX
			if (held && (!accepted_vld || sw_sync != mode_sel)) begin
				accepted_vld <= 1'b1;
				mode_change  <= 1'b1; // One cycle pulse
			end
		end
	end

	// Accepted code, updated with the pulse
	always_ff @(posedge clk50m_bufg) begin
		if (held && (!accepted_vld || sw_sync != mode_sel))
			mode_sel <= sw_sync;
	end

endmodule

//--- rtl/mode_table.sv
`timescale 1ns/10ps
`include "video_mode_params.svh"

module mode_table (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  video_mode_pkg::mode_sel_t   mode_sel,
	input  logic                       mode_change,
	output video_mode_pkg::vid_timing_t timing,
	output video_mode_pkg::md_pair_t    md
);
	import video_mode_pkg::*;

	// Cumulative compare points from live, porch and sync counts
	function automatic vid_timing_t make_timing(
		input coord_t hpix, input coord_t hfp, input coord_t hspw, input coord_t hbp,
		input coord_t vlin, input coord_t vfp, input coord_t vspw, input coord_t vbp,
		input logic   neg
	);
		vid_timing_t t;
		t.hsblnk   = hpix - coord_t'(1);
		t.hssync   = t.hsblnk + hfp;
		t.hesync   = t.hssync + hspw;
		t.heblnk   = t.hesync + hbp;
		t.vsblnk   = vlin - coord_t'(1);
		t.vssync   = t.vsblnk + vfp;
		t.vesync   = t.vssync + vspw;
		t.veblnk   = t.vesync + vbp;
		t.neg_sync = neg;
		return t;
	endfunction

	////////////////////
	// Format table
	////////////////////
	localparam vid_timing_t VGA_T = make_timing(
		`VM_VGA_HPIXELS, `VM_VGA_HFP, `VM_VGA_HSPW, `VM_VGA_HBP,
		`VM_VGA_VLINES, `VM_VGA_VFP, `VM_VGA_VSPW, `VM_VGA_VBP, `VM_VGA_NEGSYNC);
	localparam vid_timing_t SVGA_T = make_timing(
		`VM_SVGA_HPIXELS, `VM_SVGA_HFP, `VM_SVGA_HSPW, `VM_SVGA_HBP,
		`VM_SVGA_VLINES, `VM_SVGA_VFP, `VM_SVGA_VSPW, `VM_SVGA_VBP, `VM_SVGA_NEGSYNC);
	localparam vid_timing_t XGA_T = make_timing(
		`VM_XGA_HPIXELS, `VM_XGA_HFP, `VM_XGA_HSPW, `VM_XGA_HBP,
		`VM_XGA_VLINES, `VM_XGA_VFP, `VM_XGA_VSPW, `VM_XGA_VBP, `VM_XGA_NEGSYNC);
	localparam vid_timing_t SXGA_T = make_timing(
		`VM_SXGA_HPIXELS, `VM_SXGA_HFP, `VM_SXGA_HSPW, `VM_SXGA_HBP,
		`VM_SXGA_VLINES, `VM_SXGA_VFP, `VM_SXGA_VSPW, `VM_SXGA_VBP, `VM_SXGA_NEGSYNC);
	localparam vid_timing_t CAM_T = make_timing(
		`VM_CAMERA_HPIXELS, `VM_CAMERA_HFP, `VM_CAMERA_HSPW, `VM_CAMERA_HBP,
		`VM_CAMERA_VLINES, `VM_CAMERA_VFP, `VM_CAMERA_VSPW, `VM_CAMERA_VBP,
		`VM_CAMERA_NEGSYNC);
	localparam vid_timing_t HD_T = make_timing(
		`VM_HDTV720P_HPIXELS, `VM_HDTV720P_HFP, `VM_HDTV720P_HSPW, `VM_HDTV720P_HBP,
		`VM_HDTV720P_VLINES, `VM_HDTV720P_VFP, `VM_HDTV720P_VSPW, `VM_HDTV720P_VBP,
		`VM_HDTV720P_NEGSYNC);

	localparam md_pair_t HD_MD = '{m: `VM_HDTV720P_PCLK_M, d: `VM_HDTV720P_PCLK_D};

	vid_timing_t sel_timing;
	md_pair_t    sel_md;

	always_comb begin
		case (mode_sel)
			`VM_SW_VGA: begin
				sel_timing = VGA_T;
				sel_md     = '{m: `VM_VGA_PCLK_M, d: `VM_VGA_PCLK_D};
			end
			`VM_SW_SVGA: begin
				sel_timing = SVGA_T;
				sel_md     = '{m: `VM_SVGA_PCLK_M, d: `VM_SVGA_PCLK_D};
			end
			`VM_SW_XGA: begin
				sel_timing = XGA_T;
				sel_md     = '{m: `VM_XGA_PCLK_M, d: `VM_XGA_PCLK_D};
			end
			`VM_SW_SXGA: begin
				sel_timing = SXGA_T;
				sel_md     = '{m: `VM_SXGA_PCLK_M, d: `VM_SXGA_PCLK_D};
			end
			`VM_SW_CAMERA: begin
				sel_timing = CAM_T;
				sel_md     = '{m: `VM_CAMERA_PCLK_M, d: `VM_CAMERA_PCLK_D};
			end
			default: begin // 720p and every unlisted code
				sel_timing = HD_T;
				sel_md     = HD_MD;
			end
		endcase
	end

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			timing <= HD_T;
			md     <= HD_MD;
		end else if (mode_change) begin
			timing <= sel_timing;
			md     <= sel_md;
		end
	end

endmodule

//--- rtl/clkgen_prog_fsm.sv
`timescale 1ns/10ps
`include "video_mode_params.svh"

module clkgen_prog_fsm (
	input  logic                    clk50m_bufg,
	input  logic                    RSTBTN,
	input  logic                    mode_change,
	input  video_mode_pkg::md_pair_t md,
	input  logic                    progdone,
	output logic                    busy,
	output logic                    progen,
	output logic                    progdata
);
	import video_mode_pkg::*;

	localparam logic [3:0] LAST_BIT = 4'd9; // 2 command bits plus 8 value bits

	prog_state_t state;
	logic [3:0]  bit_idx;   // Position inside the current word
	md_val_t     val_sr;    // Value bits, LSB shifted out first
	logic [1:0]  cmd;
	logic        shifting;

	assign shifting = (state == SHIFT_D) || (state == SHIFT_M);
	assign cmd      = (state == SHIFT_D) ? `VM_CMD_D : `VM_CMD_M;

	////////////////////
	// Sequencer
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state   <= IDLE;
			bit_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					bit_idx <= '0;
					if (mode_change)
						state <= SHIFT_D; // Changes while busy are dropped
				end
				SHIFT_D, SHIFT_M: begin
					if (bit_idx == LAST_BIT) begin
						bit_idx <= '0;
						state   <= (state == SHIFT_D) ? GAP_D : GAP_M;
					end else begin
						bit_idx <= bit_idx + 1'b1;
					end
				end
				GAP_D:     state <= SHIFT_M;
				GAP_M:     state <= GO;
				GO:        state <= WAIT_DONE;
				WAIT_DONE: if (progdone) state <= IDLE; // Synthesizer finished
				default:   state <= IDLE;
			endcase
		end
	end

	// Value register, loaded while the command bits go out
	always_ff @(posedge clk50m_bufg) begin
		if (shifting) begin
			if (bit_idx == 4'd0)
				val_sr <= (state == SHIFT_D) ? md.d : md.m;
			else if (bit_idx >= 4'd2)
				val_sr <= val_sr >> 1;
		end
	end

	////////////////////
	// Outputs
	////////////////////
	assign busy   = (state != IDLE);
	assign progen = shifting || (state == GO); // Low in the gaps and while waiting

	always_comb begin
		progdata = 1'b0; // GO carries a zero
		if (shifting) begin
			case (bit_idx)
				4'd0:    progdata = cmd[1];
				4'd1:    progdata = cmd[0];
				default: progdata = val_sr[0];
			endcase
		end
	end

endmodule

//--- rtl/raster_timer.sv
`timescale 1ns/10ps

module raster_timer (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  logic                       busy,
	input  video_mode_pkg::vid_timing_t timing,
	output video_mode_pkg::vid_sync_t   video
);
	import video_mode_pkg::*;

	coord_t    hcnt;
	coord_t    vcnt;
	logic      line_end;
	logic      frame_end;
	logic      hblnk;
	logic      vblnk;
	logic      hsync_raw;
	logic      vsync_raw;
	vid_sync_t stage1;  // First register stage
	vid_sync_t stage2;

	assign line_end  = (hcnt == timing.heblnk);
	assign frame_end = (vcnt == timing.veblnk);

	////////////////////
	// Counters
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || busy) begin
			hcnt <= '0; // Held at start during programming
			vcnt <= '0;
		end else if (line_end) begin
			hcnt <= '0;
			vcnt <= frame_end ? '0 : vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	// Blank and sync by compare
	assign hblnk     = (hcnt > timing.hsblnk);
	assign vblnk     = (vcnt > timing.vsblnk);
	assign hsync_raw = (hcnt > timing.hssync) && (hcnt <= timing.hesync);
	assign vsync_raw = (vcnt > timing.vssync) && (vcnt <= timing.vesync);

	////////////////////
	// Output pipeline
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || busy) begin
			stage1 <= '0;
			stage2 <= '0;
		end else begin
			stage1.hsync <= hsync_raw ^ timing.neg_sync; // Polarity applied here
			stage1.vsync <= vsync_raw ^ timing.neg_sync;
			stage1.de    <= !hblnk && !vblnk;
			stage2       <= stage1;
		end
	end

	// Forced low as soon as programming starts
	assign video = busy ? '0 : stage2;

endmodule

//--- rtl/video_mode_top.sv
`timescale 1ns/10ps

module video_mode_top (
	input  logic                     clk50m_bufg,
	input  logic                     RSTBTN,
	input  video_mode_pkg::mode_sel_t sw,       // Asynchronous mode switches
	input  logic                     progdone, // Level from synthesizer
	output logic                     progen,
	output logic                     progdata,
	output logic                     busy,
	output video_mode_pkg::vid_sync_t video
);
	import video_mode_pkg::*;

	mode_sel_t   mode_sel;
	logic        mode_change;
	vid_timing_t timing;
	md_pair_t    md;

	switch_debounce u_debounce (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.mode_sel    (mode_sel),
		.mode_change (mode_change)
	);

	mode_table u_table (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode_sel    (mode_sel),
		.mode_change (mode_change),
		.timing      (timing),
		.md          (md)
	);

	clkgen_prog_fsm u_prog (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode_change (mode_change), // Same pulse as the table load
		.md          (md),
		.progdone    (progdone),
		.busy        (busy),
		.progen      (progen),
		.progdata    (progdata)
	);

	raster_timer u_raster (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.busy        (busy),
		.timing      (timing),
		.video       (video)
	);

endmodule

//--- verification/video_mode_assert.sv
`timescale 1ns/10ps

module video_mode_assert (
	input logic                      clk50m_bufg,
	input logic                      RSTBTN,
	input logic                      mode_change, // Internal debounce pulse
	input logic                      busy,
	input logic                      progen,
	input video_mode_pkg::vid_sync_t video
);

	int fail_cnt = 0; // Failed assertions so far

	// Strobe only inside a programming sequence
	progen_in_busy: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		progen |-> busy)
		else begin
			fail_cnt++;
			$error("progen high while not busy");
		end

	// Raster blanked during programming
	de_low_in_busy: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		busy |-> !video.de)
		else begin
			fail_cnt++;
			$error("de high while busy");
		end

	// Programming only starts from an accepted switch change
	busy_after_change: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		$rose(busy) |-> $past(mode_change))
		else begin
			fail_cnt++;
			$error("busy rose without a mode_change pulse");
		end

endmodule

bind video_mode_top video_mode_assert u_assert (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.mode_change (mode_change),
	.busy        (busy),
	.progen      (progen),
	.video       (video)
);

//--- verification/video_mode_tb.sv
`timescale 1ns/10ps
`include "video_mode_params.svh"

module video_mode_tb;
	import video_mode_pkg::*;

	localparam int BUSY_WAIT = 64;   // Debounce plus sync margin
	localparam int WORD_WAIT = 16;
	localparam int LINE_WAIT = 4096; // Over two of the longest lines

	typedef struct {
		string     name;
		mode_sel_t code;
		int        hold;     // Pulse length in cycles or 0 to keep the code
		int        m;
		int        d;
		int        line_len;
		int        hs_width;
		int        de_width;
		logic      neg;      // Active low sync
	} test_row_t;

	logic        clk50m_bufg;
	logic        RSTBTN;
	mode_sel_t   sw;
	logic        progdone;
	logic        progen;
	logic        progdata;
	logic        busy;
	vid_sync_t   video;

	test_row_t   rows[$];
	mode_sel_t   cur_sw;             // Code the DUT should hold
	int          errors = 0;
	int          busy_rises = 0;
	logic        busy_q = 1'b0;
	logic        timed_out = 1'b0;
	logic [31:0] lfsr_state = 32'h942e_b6a9;

	video_mode_top dut_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.progdone    (progdone),
		.progen      (progen),
		.progdata    (progdata),
		.busy        (busy),
		.video       (video)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;
	end

	// Programming sequences started
	always @(posedge clk50m_bufg) begin
		busy_q <= busy;
		if (busy && !busy_q)
			busy_rises <= busy_rises + 1;
	end

	////////////////////
	// Helpers
	////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois form with taps 32 22 2 1
	endfunction

	task automatic draw_bits(input int n, output int v);
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			v = (v << 1) | lfsr_state[0]; // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_value(input string name, input string what, input int exp,
		input int act);
		if (exp != act) begin
			$display("[ERROR] %s %s: expected %0d, actual %0d", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic add_row(input string name, input mode_sel_t code, input int hold,
		input int m, input int d, input int line_len, input int hs_width,
		input int de_width, input logic neg);
		test_row_t t;
		t = '{name, code, hold, m, d, line_len, hs_width, de_width, neg};
		rows.push_back(t);
	endtask

	// Bits in send order plus the gap cycles before the word
	task automatic read_word(output logic [9:0] bits, output int nbits, output int gap);
		bits  = '0;
		nbits = 0;
		gap   = 0;
		while (!progen && gap < WORD_WAIT) begin
			@(negedge clk50m_bufg);
			gap++;
		end
		if (!progen) begin
			$display("Timeout: progen did not rise within %0d cycles", WORD_WAIT);
			timed_out = 1'b1;
			return;
		end
		while (progen && nbits < WORD_WAIT) begin
			if (nbits < 10)
				bits[nbits] = progdata;
			nbits++;
			@(negedge clk50m_bufg);
		end
		if (progen) begin
			$display("Timeout: progen stayed high for %0d cycles", WORD_WAIT);
			timed_out = 1'b1;
		end
	endtask

	////////////////////
	// Synthesizer model
	////////////////////
	task automatic answer_go(input string name);
		int delay;
		int i;
		draw_bits(4, delay); // Varies the wait length
		for (i = 0; i <= delay; i++) begin
			if (!busy) begin
				$display("Test %s: busy fell before progdone", name);
				errors++;
			end
			if (i < delay)
				@(negedge clk50m_bufg);
		end
		progdone = 1'b1;
		@(negedge clk50m_bufg);
		if (busy) begin
			$display("Test %s: busy still high one cycle after progdone", name);
			errors++;
		end
		progdone = 1'b0;
	endtask

	task automatic check_program(input test_row_t t);
		logic [9:0] bits;
		int nbits;
		int gap;
		int n;
		n = 0;
		while (!busy && n < BUSY_WAIT) begin
			@(negedge clk50m_bufg);
			n++;
		end
		if (!busy) begin
			$display("Timeout: busy did not rise in test %s", t.name);
			timed_out = 1'b1;
			return;
		end
		read_word(bits, nbits, gap); // D word starts with busy
		if (timed_out)
			return;
		check_value(t.name, "D gap", 0, gap);
		check_value(t.name, "D length", 10, nbits);
		check_value(t.name, "D command", 2, {bits[0], bits[1]});
		check_value(t.name, "D value", t.d, bits[9:2]); // LSB sent first
		read_word(bits, nbits, gap);
		if (timed_out)
			return;
		check_value(t.name, "M gap", 1, gap);
		check_value(t.name, "M length", 10, nbits);
		check_value(t.name, "M command", 3, {bits[0], bits[1]});
		check_value(t.name, "M value", t.m, bits[9:2]);
		read_word(bits, nbits, gap); // GO
		if (timed_out)
			return;
		check_value(t.name, "GO gap", 1, gap);
		check_value(t.name, "GO length", 1, nbits);
		check_value(t.name, "GO data", 0, bits[0]);
		answer_go(t.name);
	endtask

	////////////////////
	// Line monitor
	////////////////////
	task automatic measure_line(input logic neg, output int len, output int hs_w,
		output int de_w, output logic idle_lvl, output logic vs_lvl);
		logic prev;
		logic act;
		logic found;
		int   n;
		len      = 0;
		hs_w     = 0;
		de_w     = 0;
		idle_lvl = !neg;
		vs_lvl   = !neg;
		n        = 0;
		found    = 1'b0;
		prev     = video.hsync ^ neg;
		while (!found && n < LINE_WAIT) begin // First active edge
			@(negedge clk50m_bufg);
			n++;
			act   = video.hsync ^ neg;
			found = act && !prev;
			prev  = act;
		end
		if (!found) begin
			$display("Timeout: no hsync edge within %0d cycles", LINE_WAIT);
			timed_out = 1'b1;
			return;
		end
		found = 1'b0;
		while (!found && len < LINE_WAIT) begin // Up to the next edge
			if (video.hsync ^ neg)
				hs_w++;
			if (video.de) begin
				de_w++;
				idle_lvl = video.hsync;
				vs_lvl   = video.vsync; // Live line so vsync is idle
			end
			@(negedge clk50m_bufg);
			len++;
			act   = video.hsync ^ neg;
			found = act && !prev;
			prev  = act;
		end
		if (!found) begin
			$display("Timeout: second hsync edge missing after %0d cycles", LINE_WAIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_row(input test_row_t t);
		int   rises0;
		int   len;
		int   hs_w;
		int   de_w;
		logic idle_lvl;
		logic vs_lvl;
		rises0 = busy_rises;
		sw     = t.code;
		if (t.hold != 0) begin
			repeat (t.hold) @(negedge clk50m_bufg); // Short pulse
			sw = cur_sw;
		end else begin
			cur_sw = t.code;
			check_program(t);
		end
		if (timed_out)
			return;
		measure_line(t.neg, len, hs_w, de_w, idle_lvl, vs_lvl);
		if (timed_out)
			return;
		check_value(t.name, "line length", t.line_len, len);
		check_value(t.name, "hsync width", t.hs_width, hs_w);
		check_value(t.name, "de width", t.de_width, de_w);
		check_value(t.name, "hsync idle level", t.neg, idle_lvl);
		check_value(t.name, "vsync idle level", t.neg, vs_lvl);
		check_value(t.name, "programming runs", (t.hold == 0) ? 1 : 0, busy_rises - rises0);
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		int r;
		int errs0;
		int failed_tests;
		RSTBTN   = 1'b1;
		progdone = 1'b0;
		sw       = `VM_SW_VGA;
		failed_tests = 0;
		//      name      code          hold  M    D    line  hs   de    neg
		add_row("vga",    `VM_SW_VGA,   0,    1,   3,   800,  96,  640,  1'b1);
		add_row("svga",   `VM_SW_SVGA,  0,    3,   4,   1056, 128, 800,  1'b0);
		add_row("glitch", `VM_SW_XGA,   8,    0,   0,   1056, 128, 800,  1'b0);
		add_row("unlist", 4'b0111,      0,    247, 166, 1650, 40,  1280, 1'b0);
		add_row("sxga",   `VM_SW_SXGA,  0,    53,  24,  1688, 112, 1280, 1'b0);
		cur_sw = `VM_SW_VGA;
		repeat (4) @(negedge clk50m_bufg);
		RSTBTN = 1'b0;
		errs0  = errors;
		check_value("reset", "progen", 0, progen);
		check_value("reset", "progdata", 0, progdata);
		check_value("reset", "busy", 0, busy);
		check_value("reset", "de", 0, video.de);
		$display("Reset values: %s", (errors == errs0) ? "ok" : "wrong");
		for (r = 0; r < rows.size() && !timed_out; r++) begin
			errs0 = errors;
			run_row(rows[r]);
			if (errors != errs0 || timed_out)
				failed_tests++;
			$display("Test %0d %s: %s", r, rows[r].name,
				(errors == errs0 && !timed_out) ? "ok" : "failed");
		end
		$display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
			r, failed_tests, errors, dut_i.u_assert.fail_cnt);
		if (errors == 0 && !timed_out && dut_i.u_assert.fail_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+rtl
rtl/video_mode_pkg.sv
rtl/switch_debounce.sv
rtl/mode_table.sv
rtl/clkgen_prog_fsm.sv
rtl/raster_timer.sv
rtl/video_mode_top.sv
verification/video_mode_assert.sv
verification/video_mode_tb.sv

//--- Bender.yml
package:
  name: video_mode

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/video_mode_pkg.sv
      - rtl/switch_debounce.sv
      - rtl/mode_table.sv
      - rtl/clkgen_prog_fsm.sv
      - rtl/raster_timer.sv
      - rtl/video_mode_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/video_mode_assert.sv
      - verification/video_mode_tb.sv
